// ==== spw_tx.f ====
+incdir+tb
source/spw_tx_pkg.sv
source/tx_link_fsm.sv
source/tx_bit_counter.sv
source/tx_credit_ledger.sv
source/tx_char_serializer.sv
source/tx_ds_encoder.sv
source/spw_tx.sv
tb/tb_spw_tx.sv

// ==== Bender.yml ====
package:
  name: spw_tx

sources:
  - files:
      - source/spw_tx_pkg.sv
      - source/tx_link_fsm.sv
      - source/tx_bit_counter.sv
      - source/tx_credit_ledger.sv
      - source/tx_char_serializer.sv
      - source/tx_ds_encoder.sv
      - source/spw_tx.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_spw_tx.sv

// ==== tb/tb_spw_tx_model.svh ====
`ifndef TB_SPW_TX_MODEL_SVH
`define TB_SPW_TX_MODEL_SVH

// ------------------------------
// Reference model
// ------------------------------

// Pattern written in send order, first bit on the left
function automatic logic [8:0] in_send_order(logic [8:0] pattern, int n);
	logic [8:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v[i] = pattern[n-1-i];
	return v;
endfunction

// Odd parity, the ones in payload, flag and parity bit add up to an odd count
function automatic logic ref_parity(logic [7:0] prev_payload, logic flag);
	logic ones;
	ones = flag;
	for (int i = 0; i < 8; i++)
		ones = ones ^ prev_payload[i];
	return ~ones;
endfunction

function automatic int ref_len(logic [KIND_W-1:0] kind, logic [8:0] word);
	if (kind == KIND_NULL)
		return 8;
	else if ((kind == KIND_NCHAR) && !word[8])
		return 10;
	else
		return 4;
endfunction

// Bit i of the result is the i-th bit on the line
function automatic logic [9:0] ref_bits(logic [KIND_W-1:0] kind, logic [8:0] word,
		logic [7:0] prev_payload);
	logic [8:0] rest;
	case (kind)
		KIND_FCT:
			rest = in_send_order(9'b100, 3);
		KIND_NCHAR:
		begin
			if (!word[8])
				rest = {word[7:0], 1'b0};
			else if (word[1:0] == CODE_EOP)
				rest = in_send_order(9'b101, 3);
			else
				rest = in_send_order(9'b110, 3);
		end
		default:
			rest = in_send_order(9'b1110100, 7);
	endcase
	return {rest, ref_parity(prev_payload, rest[0])};
endfunction

// Payload that the next character's parity covers
function automatic logic [7:0] ref_payload(logic [KIND_W-1:0] kind, logic [8:0] word);
	if (kind != KIND_NCHAR)
		return 8'h00;
	else if (!word[8])
		return word[7:0];
	else if (word[1:0] == CODE_EOP)
		return 8'b01;
	else
		return 8'b10;
endfunction

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// ==== tb/tb_spw_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spw_tx
	import spw_tx_pkg::*;
();

	logic pclk_tx;
	logic enable_tx;
	logic send_null_tx;
	logic send_fct_tx;
	logic gotfct_tx;
	logic send_fct_now;
	spw_char_u data_tx_i;
	logic txwrite_tx;
	logic tx_dout_e;
	logic tx_sout_e;
	logic ready_tx_data;

	logic [31:0] lfsr;
	logic [8:0] offer_q[$];
	logic [8:0] exp_word_q[$];
	logic [9:0] got_bits_q[$];
	int got_len_q[$];
	logic word_taken = 1'b0;
	int ready_cnt = 0;
	int null_cnt = 0;
	int fct_cnt = 0;
	int nchar_cnt = 0;
	logic [7:0] prev_payload = 8'h00;
	logic [9:0] dec_bits = '0;
	int dec_len = 0;
	logic char_done;
	logic last_d = 1'b0;
	logic last_s = 1'b0;
	logic line_live = 1'b0;

	`include "tb_spw_tx_model.svh"

	spw_tx uut (
		.pclk_tx       (pclk_tx),
		.enable_tx     (enable_tx),
		.send_null_tx  (send_null_tx),
		.send_fct_tx   (send_fct_tx),
		.gotfct_tx     (gotfct_tx),
		.send_fct_now  (send_fct_now),
		.data_tx_i     (data_tx_i),
		.txwrite_tx    (txwrite_tx),
		.tx_dout_e     (tx_dout_e),
		.tx_sout_e     (tx_sout_e),
		.ready_tx_data (ready_tx_data)
	);

	always #20 pclk_tx = ~pclk_tx;

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_eq(logic [31:0] got, logic [31:0] exp, string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic next_edge();
		@(posedge pclk_tx);
		#2;
	endtask

	function automatic int count_of(logic [KIND_W-1:0] kind);
		if (kind == KIND_NULL)
			return null_cnt;
		else if (kind == KIND_FCT)
			return fct_cnt;
		else
			return nchar_cnt;
	endfunction

	task automatic wait_until(logic [KIND_W-1:0] kind, int target, string what);
		int cycles;
		cycles = 0;
		while (count_of(kind) < target)
		begin
			next_edge();
			cycles++;
			if (cycles > 4000)
			begin
				$display("Timed out at %0t ns waiting for %s", $time, what);
				abort_run();
			end
		end
	endtask

	task automatic pulse_gotfct();
		gotfct_tx = 1'b1;
		next_edge();
		gotfct_tx = 1'b0;
		next_edge();
	endtask

	task automatic take_bits(int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[31]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// Mostly data bytes with some EOP and EEP carrying random unused bits
	task automatic offer_random(int count);
		logic [31:0] pick;
		logic [31:0] r;
		@(negedge pclk_tx);
		for (int i = 0; i < count; i++)
		begin
			take_bits(3, pick);
			if (pick[2:0] < 3'd6)
			begin
				take_bits(8, r);
				offer_q.push_back({1'b0, r[7:0]});
			end
			else
			begin
				take_bits(6, r);
				offer_q.push_back({1'b1, r[5:0], (pick[0] ? CODE_EEP : CODE_EOP)});
			end
		end
	endtask

	// ------------------------------
	// Writer side of the handshake
	// ------------------------------
	always @(posedge pclk_tx)
	begin
		#2;
		if (word_taken)
			offer_q.delete(0);
		word_taken = 1'b0;
		if (offer_q.size() != 0)
		begin
			data_tx_i = offer_q[0];
			txwrite_tx = 1'b1;
		end
		else
			txwrite_tx = 1'b0;
	end

	always @(negedge pclk_tx)
	begin
		if (ready_tx_data)
		begin
			check_eq(txwrite_tx, 1, "ready_tx_data without txwrite_tx");
			exp_word_q.push_back(data_tx_i);
			ready_cnt++;
			word_taken = 1'b1;
		end
	end

	// ------------------------------
	// Line decoder
	// ------------------------------
	always @(negedge pclk_tx)
	begin
		if (enable_tx)
		begin
			check_eq((tx_dout_e != last_d) && (tx_sout_e != last_s), 0,
				"data and strobe changed in the same cycle");
			if (line_live)
				check_eq((tx_dout_e != last_d) || (tx_sout_e != last_s), 1,
					"bit period without a line change");
			if ((tx_dout_e != last_d) || (tx_sout_e != last_s))
			begin
				line_live = 1'b1;
				dec_bits[dec_len] = tx_dout_e;
				dec_len++;
				// ESC code 1,1 means a NULL, so read on to eight bits
				if (dec_bits[1])
					char_done = (dec_len == 8) ||
						((dec_len == 4) && !(dec_bits[2] && dec_bits[3]));
				else
					char_done = (dec_len == 10);
				if (char_done)
				begin
					got_bits_q.push_back(dec_bits);
					got_len_q.push_back(dec_len);
					dec_bits = '0;
					dec_len = 0;
				end
			end
			last_d = tx_dout_e;
			last_s = tx_sout_e;
		end
	end

	// ------------------------------
	// Character compare
	// ------------------------------
	task automatic compare_char(logic [9:0] bits, int len);
		logic [KIND_W-1:0] kind;
		logic [8:0] word;
		logic [9:0] exp_bits;
		kind = KIND_NCHAR;
		word = '0;
		if (len == 8)
			kind = KIND_NULL;
		else if ((len == 4) && !bits[2] && !bits[3])
			kind = KIND_FCT;
		if (kind == KIND_NCHAR)
		begin
			check_eq(exp_word_q.size() != 0, 1, "normal character without a taken word");
			word = exp_word_q.pop_front();
			nchar_cnt++;
		end
		else if (kind == KIND_FCT)
			fct_cnt++;
		else
			null_cnt++;
		exp_bits = ref_bits(kind, word, prev_payload);
		check_eq(len, ref_len(kind, word), "character length");
		check_eq(bits[0], exp_bits[0], "parity bit");
		check_eq(bits, exp_bits, "character bits");
		prev_payload = ref_payload(kind, word);
	endtask

	always @(posedge pclk_tx)
	begin
		if (got_bits_q.size() != 0)
			compare_char(got_bits_q.pop_front(), got_len_q.pop_front());
	end

	initial
	begin
		pclk_tx = 1'b0;
		enable_tx = 1'b0;
		send_null_tx = 1'b0;
		send_fct_tx = 1'b0;
		gotfct_tx = 1'b0;
		send_fct_now = 1'b0;
		txwrite_tx = 1'b0;
		data_tx_i = '0;
		lfsr = 32'h8d627da9;
		repeat (4)
			@(posedge pclk_tx);
		#2;
		enable_tx = 1'b1;

		// Idle until the link controller asks for NULLs
		repeat (12)
		begin
			next_edge();
			check_eq({tx_dout_e, tx_sout_e, ready_tx_data}, 0, "outputs while idle");
		end
		send_null_tx = 1'b1;
		wait_until(KIND_NULL, 3, "the first NULLs");
		check_eq(fct_cnt + nchar_cnt, 0, "characters other than NULL");

		send_fct_tx = 1'b1;
		wait_until(KIND_FCT, FCT_INIT, "the start-up FCTs");
		wait_until(KIND_NULL, null_cnt + 3, "NULLs after the start-up FCTs");
		check_eq(fct_cnt, FCT_INIT, "start-up FCT count");
		send_fct_now = 1'b1;
		next_edge();
		send_fct_now = 1'b0;
		wait_until(KIND_FCT, FCT_INIT + 1, "the FCT for freed space");
		wait_until(KIND_NULL, null_cnt + 3, "NULLs after the extra FCT");
		check_eq(fct_cnt, FCT_INIT + 1, "FCT count after send_fct_now");

		// Twelve words wait on zero credit until FCTs arrive
		offer_random(12);
		wait_until(KIND_NULL, null_cnt + 4, "NULLs while credit is zero");
		check_eq(ready_cnt, 0, "words taken without credit");
		pulse_gotfct();
		wait_until(KIND_NCHAR, 8, "the first eight words");
		wait_until(KIND_NULL, null_cnt + 3, "NULLs after the credit ran out");
		check_eq(nchar_cnt, 8, "words sent on eight credits");
		check_eq(ready_cnt, 8, "ready_tx_data pulses on eight credits");
		pulse_gotfct();
		wait_until(KIND_NCHAR, 12, "the last four words");

		repeat (3)
			pulse_gotfct();
		offer_random(20);
		wait_until(KIND_NCHAR, 32, "the random words");
		wait_until(KIND_NULL, null_cnt + 3, "NULLs after the random words");
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/spw_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module spw_tx
	import spw_tx_pkg::*;
(
	input  wire logic      pclk_tx,
	input  wire logic      enable_tx,
	input  wire logic      send_null_tx,
	input  wire logic      send_fct_tx,
	input  wire logic      gotfct_tx,
	input  wire logic      send_fct_now,
	input  wire spw_char_u data_tx_i,
	input  wire logic      txwrite_tx,
	output logic           tx_dout_e,
	output logic           tx_sout_e,
	output logic           ready_tx_data
);

	logic char_load;
	logic [KIND_W-1:0] char_kind;
	logic char_last;
	logic data_flag;
	logic credit_avail;
	logic fct_pending;
	logic fct_sent;
	logic nchar_sent;
	logic bit_valid;
	logic bit_out;

	tx_link_fsm u_link_fsm (
		.pclk_tx       (pclk_tx),
		.enable_tx     (enable_tx),
		.send_null_tx  (send_null_tx),
		.send_fct_tx   (send_fct_tx),
		.txwrite_tx    (txwrite_tx),
		.char_last     (char_last),
		.credit_avail  (credit_avail),
		.fct_pending   (fct_pending),
		.char_load     (char_load),
		.char_kind     (char_kind),
		.ready_tx_data (ready_tx_data),
		.fct_sent      (fct_sent),
		.nchar_sent    (nchar_sent)
	);

	tx_bit_counter u_bit_counter (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.char_load (char_load),
		.char_kind (char_kind),
		.data_flag (data_flag),
		.char_last (char_last)
	);

	tx_credit_ledger u_credit_ledger (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.gotfct_tx    (gotfct_tx),
		.send_fct_now (send_fct_now),
		.fct_sent     (fct_sent),
		.nchar_sent   (nchar_sent),
		.credit_avail (credit_avail),
		.fct_pending  (fct_pending)
	);

	tx_char_serializer u_char_serializer (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.char_load (char_load),
		.char_kind (char_kind),
		.data_tx_i (data_tx_i),
		.data_flag (data_flag),
		.bit_valid (bit_valid),
		.bit_out   (bit_out)
	);

	tx_ds_encoder u_ds_encoder (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.bit_valid (bit_valid),
		.bit_out   (bit_out),
		.tx_dout_e (tx_dout_e),
		.tx_sout_e (tx_sout_e)
	);

endmodule

`default_nettype wire

// ==== source/tx_ds_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_ds_encoder (
	input  wire logic pclk_tx,
	input  wire logic enable_tx,
	input  wire logic bit_valid,
	input  wire logic bit_out,
	output logic      tx_dout_e,
	output logic      tx_sout_e
);

	logic dout_nxt;
	logic sout_nxt;

	// Strobe toggles only when data repeats
	always_comb
	begin
		dout_nxt = tx_dout_e;
		sout_nxt = tx_sout_e;
		if (bit_valid)
		begin
			dout_nxt = bit_out;
			if (bit_out == tx_dout_e)
				sout_nxt = ~tx_sout_e;
		end
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			tx_dout_e <= 1'b0;
			tx_sout_e <= 1'b0;
		end
		else
		begin
			tx_dout_e <= dout_nxt;
			tx_sout_e <= sout_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== source/tx_char_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_char_serializer
	import spw_tx_pkg::*;
(
	input  wire logic              pclk_tx,
	input  wire logic              enable_tx,
	input  wire logic              char_load,
	input  wire logic [KIND_W-1:0] char_kind,
	input  wire spw_char_u         data_tx_i,
	output logic                   data_flag,
	output logic                   bit_valid,
	output logic                   bit_out
);

	// Bits after the parity bit, first sent in bit 0
	logic [CHAR_W-1:0] bits_nxt;
	logic [7:0] payload_nxt;
	logic [7:0] payload_q;
	logic parity;

	// Parity in bit 0, shifted out towards the LSB
	logic [CHAR_W:0] sreg;
	logic active;

	assign data_flag = data_tx_i.data.flag;

	always_comb
	begin
		bits_nxt = {2'b00, 7'b0010111};
		payload_nxt = 8'h00;
		case (char_kind)
			KIND_FCT:
			begin
				bits_nxt = {6'b000000, 3'b001};
				payload_nxt = 8'h00;
			end
			KIND_NCHAR:
			begin
				if (data_tx_i.ctrl.flag)
				begin
					// EOP sends 1,0,1 and EEP sends 1,1,0
					if (data_tx_i.ctrl.code == CODE_EOP)
						bits_nxt = {6'b000000, 3'b101};
					else
						bits_nxt = {6'b000000, 3'b011};
					payload_nxt = {6'b000000, bits_nxt[2:1]};
				end
				else
				begin
					bits_nxt = {data_tx_i.data.data_byte, 1'b0};
					payload_nxt = data_tx_i.data.data_byte;
				end
			end
			default:
			begin
				// ESC then FCT, payload is the trailing 0,0
				bits_nxt = {2'b00, 7'b0010111};
				payload_nxt = 8'h00;
			end
		endcase
	end

	// Odd parity over the previous payload and the new flag
	assign parity = ~(^payload_q ^ bits_nxt[0]);

	assign bit_valid = active;
	assign bit_out = sreg[0];

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			sreg <= '0;
			payload_q <= 8'h00;
			active <= 1'b0;
		end
		else if (char_load)
		begin
			sreg <= {bits_nxt, parity};
			payload_q <= payload_nxt;
			active <= 1'b1;
		end
		else
		begin
			sreg <= {1'b0, sreg[CHAR_W:1]};
		end
	end

endmodule

`default_nettype wire

// ==== source/tx_credit_ledger.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_credit_ledger
	import spw_tx_pkg::*;
(
	input  wire logic pclk_tx,
	input  wire logic enable_tx,
	input  wire logic gotfct_tx,
	input  wire logic send_fct_now,
	input  wire logic fct_sent,
	input  wire logic nchar_sent,
	output logic      credit_avail,
	output logic      fct_pending
);

	logic got_q;
	logic now_q;
	logic got_rise;
	logic now_rise;

	logic [CREDIT_W:0] credit_sum;
	logic [CREDIT_W-1:0] credit_clip;
	logic [CREDIT_W-1:0] credit;

	logic [FCT_PEND_W:0] pend_sum;
	logic [FCT_PEND_W-1:0] pend;

	assign got_rise = gotfct_tx & ~got_q;
	assign now_rise = send_fct_now & ~now_q;

	// Ceiling applies to the FCT step, the send comes off afterwards
	assign credit_sum = {1'b0, credit} + (got_rise ? {1'b0, CREDIT_STEP} : '0);
	assign credit_clip = (credit_sum > {1'b0, CREDIT_MAX}) ?
		CREDIT_MAX : credit_sum[CREDIT_W-1:0];

	assign pend_sum = {1'b0, pend} + {{FCT_PEND_W{1'b0}}, now_rise}
		- {{FCT_PEND_W{1'b0}}, fct_sent};

	assign credit_avail = (credit != '0);
	assign fct_pending = (pend != '0);

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			got_q <= 1'b0;
			now_q <= 1'b0;
			credit <= '0;
			pend <= FCT_INIT;
		end
		else
		begin
			got_q <= gotfct_tx;
			now_q <= send_fct_now;
			credit <= credit_clip - {{(CREDIT_W-1){1'b0}}, nchar_sent};
			if (pend_sum > {1'b0, FCT_PEND_MAX})
				pend <= FCT_PEND_MAX;
			else
				pend <= pend_sum[FCT_PEND_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/tx_bit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_bit_counter
	import spw_tx_pkg::*;
(
	input  wire logic              pclk_tx,
	input  wire logic              enable_tx,
	input  wire logic              char_load,
	input  wire logic [KIND_W-1:0] char_kind,
	input  wire logic              data_flag,
	output logic                   char_last
);

	logic [BITCNT_W-1:0] len;
	logic [BITCNT_W-1:0] cnt;

	always_comb
	begin
		case (char_kind)
			KIND_FCT:   len = LEN_FCT;
			KIND_NCHAR: len = data_flag ? LEN_CTRL : LEN_DATA;
			default:    len = LEN_NULL;
		endcase
	end

	// Reaches 1 on the final bit of the character
	assign char_last = (cnt == BITCNT_W'(1));

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			cnt <= '0;
		else if (char_load)
			cnt <= len;
		else if (cnt != '0)
			cnt <= cnt - BITCNT_W'(1);
	end

endmodule

`default_nettype wire

// ==== source/tx_link_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_link_fsm
	import spw_tx_pkg::*;
(
	input  wire logic              pclk_tx,
	input  wire logic              enable_tx,
	input  wire logic              send_null_tx,
	input  wire logic              send_fct_tx,
	input  wire logic              txwrite_tx,
	input  wire logic              char_last,
	input  wire logic              credit_avail,
	input  wire logic              fct_pending,
	output logic                   char_load,
	output logic [KIND_W-1:0]      char_kind,
	output logic                   ready_tx_data,
	output logic                   fct_sent,
	output logic                   nchar_sent
);

	logic [LINK_W-1:0] state;
	logic [LINK_W-1:0] state_nxt;
	logic start_q;

	// First NULL starts right after leaving START, then one per boundary
	assign char_load = char_last | start_q;

	always_comb
	begin
		char_kind = KIND_NULL;
		case (state)
			LINK_NULL_FCT:
			begin
				if (fct_pending)
					char_kind = KIND_FCT;
			end
			LINK_FULL:
			begin
				if (fct_pending)
					char_kind = KIND_FCT;
				else if (txwrite_tx && credit_avail)
					char_kind = KIND_NCHAR;
			end
			default:
			begin
				char_kind = KIND_NULL;
			end
		endcase
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			LINK_START:
			begin
				if (send_null_tx)
					state_nxt = LINK_NULL;
			end
			LINK_NULL:
			begin
				if (char_load && send_fct_tx)
					state_nxt = LINK_NULL_FCT;
			end
			LINK_NULL_FCT:
			begin
				if (char_load && credit_avail)
					state_nxt = LINK_FULL;
			end
			default:
			begin
				state_nxt = state;
			end
		endcase
	end

	// Word is taken in the same cycle it is chosen
	assign ready_tx_data = char_load && (char_kind == KIND_NCHAR);
	assign nchar_sent = ready_tx_data;
	assign fct_sent = char_load && (char_kind == KIND_FCT);

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state <= LINK_START;
			start_q <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			start_q <= (state == LINK_START) && send_null_tx;
		end
	end

endmodule

`default_nettype wire

// ==== source/spw_tx_pkg.sv ====
`default_nettype none

package spw_tx_pkg;

	// ------------------------------
	// Character word and credit
	// ------------------------------
	localparam int CHAR_W = 9;

	localparam int CREDIT_W = 6;
	localparam logic [CREDIT_W-1:0] CREDIT_STEP = 6'd8;
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = 6'd56;

	localparam int FCT_PEND_W = 3;
	localparam logic [FCT_PEND_W-1:0] FCT_PEND_MAX = 3'd7;
	localparam logic [FCT_PEND_W-1:0] FCT_INIT = 3'd7;

	// ------------------------------
	// Character kinds and lengths
	// ------------------------------
	localparam int KIND_W = 2;
	localparam logic [KIND_W-1:0] KIND_NULL = 2'd0;
	localparam logic [KIND_W-1:0] KIND_FCT = 2'd1;
	localparam logic [KIND_W-1:0] KIND_NCHAR = 2'd2;

	// Lengths include the parity bit
	localparam int BITCNT_W = 4;
	localparam logic [BITCNT_W-1:0] LEN_NULL = 4'd8;
	localparam logic [BITCNT_W-1:0] LEN_FCT = 4'd4;
	localparam logic [BITCNT_W-1:0] LEN_DATA = 4'd10;
	localparam logic [BITCNT_W-1:0] LEN_CTRL = 4'd4;

	localparam int LINK_W = 2;
	localparam logic [LINK_W-1:0] LINK_START = 2'd0;
	localparam logic [LINK_W-1:0] LINK_NULL = 2'd1;
	localparam logic [LINK_W-1:0] LINK_NULL_FCT = 2'd2;
	localparam logic [LINK_W-1:0] LINK_FULL = 2'd3;

	localparam logic [1:0] CODE_EOP = 2'd0;
	localparam logic [1:0] CODE_EEP = 2'd1;

	// Flag is bit 8 in both views
	typedef union packed {
		struct packed {
			logic flag;
			logic [CHAR_W-2:0] data_byte;
		} data;
		struct packed {
			logic flag;
			logic [5:0] unused;
			logic [1:0] code;
		} ctrl;
	} spw_char_u;

endpackage

`default_nettype wire
